// ==== Bender.yml ====
package:
  name: rs_station

sources:
  - include_dirs:
      - source
    files:
      - source/rs_pkg.sv
      - source/rs_dispatch.sv
      - source/rs_entry.sv
      - source/rs_issue_select.sv
      - source/rs_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/rs_tb.sv

// ==== files.f ====
+incdir+source
source/rs_pkg.sv
source/rs_dispatch.sv
source/rs_entry.sv
source/rs_issue_select.sv
source/rs_top.sv
verification/rs_tb.sv

// ==== source/rs_cfg.svh ====
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// ##################################################
// station array sizing
// ##################################################

`define RS_SZ 5 // alu, load, store, two multiply.

// ##################################################
// word layout
// ##################################################

`define RS_TAG_W 6 // tag zero means no dependence.
`define RS_IMM_W 12
`define RS_WORD_W 27 // fmt + class + dest + src1 + 12-bit tail.

// station index to unit class encoding.
// 0 alu, 1 load, 2 store, 3 and up multiply.
`define RS_CLASS_OF(i) (((i) > 2) ? 2'd3 : 2'((i)))

`endif

// ==== source/rs_dispatch.sv ====
`default_nettype none

`include "rs_cfg.svh"

module rs_dispatch (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch_cyc,
	input  logic                  dispatch_stb,
	input  logic                  dispatch_we,
	input  logic [`RS_WORD_W-1:0] dispatch_dat,
	output logic                  dispatch_ack,
	input  logic [`RS_SZ-1:0]     busy,
	output logic [`RS_SZ-1:0]     write_en,
	output rs_pkg::rs_op_u        write_word
);

	rs_pkg::rs_op_u       word;
	logic                 take;
	logic [`RS_SZ-1:0]    candidate;
	logic [`RS_SZ-1:0]    pick;
	logic                 class_free;

	// ##################################################
	// bus decode
	// ##################################################

	assign word.raw = dispatch_dat;
	assign write_word = word;

	// a new write only while no ack is outstanding.
	assign take = dispatch_cyc && dispatch_stb && dispatch_we && !dispatch_ack;

	// ##################################################
	// station choice
	// ##################################################

	always_comb begin
		for (int i = 0; i < `RS_SZ; i++) begin
			candidate[i] = !busy[i] && (`RS_CLASS_OF(i) == word.reg_form.unit_class);
		end
	end

	assign class_free = |candidate;
	assign pick = candidate & (~candidate + 1'b1); // lowest free index wins.

	// station captures at the same edge that raises ack.
	assign write_en = (take && class_free) ? pick : '0;

	// ##################################################
	// acknowledge
	// ##################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			dispatch_ack <= 1'b0;
		end else begin
			dispatch_ack <= |write_en; // held low while the class is full.
		end
	end

	// master must keep the cycle open until it sees ack.
	ack_inside_cycle: assert property (
		@(posedge clock) disable iff (reset)
		dispatch_ack |-> (dispatch_cyc && dispatch_stb)
	) else $error("dispatch_ack outside an open cycle");

endmodule

`default_nettype wire

// ==== source/rs_entry.sv ====
`default_nettype none

`include "rs_cfg.svh"

module rs_entry (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 write_en,
	input  rs_pkg::rs_op_u       write_word,
	input  logic                 cdb_valid,
	input  logic [`RS_TAG_W-1:0] cdb_tag,
	input  logic                 grant,
	output logic                 busy,
	output logic                 request,
	output rs_pkg::rs_op_u       held_word
);

	logic ready1;
	logic ready2;
	logic in_imm;
	logic in_ready1;
	logic in_ready2;
	logic held_imm;
	logic wake1;
	logic wake2;

	// ##################################################
	// operand readiness
	// ##################################################

	assign in_imm = (write_word.imm_form.fmt == rs_pkg::fmt_imm);

	// incoming sources also see a broadcast in the dispatch cycle.
	assign in_ready1 = (write_word.reg_form.src1 == '0)
		|| (cdb_valid && (cdb_tag == write_word.reg_form.src1));
	assign in_ready2 = in_imm || (write_word.reg_form.src2 == '0)
		|| (cdb_valid && (cdb_tag == write_word.reg_form.src2));

	assign held_imm = (held_word.imm_form.fmt == rs_pkg::fmt_imm);
	assign wake1 = cdb_valid && (cdb_tag == held_word.reg_form.src1);
	assign wake2 = cdb_valid && !held_imm && (cdb_tag == held_word.reg_form.src2); // imm is no tag.

	// ##################################################
	// station state
	// ##################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			request <= 1'b0;
			ready1  <= 1'b0;
			ready2  <= 1'b0;
		end else if (write_en) begin
			busy    <= 1'b1;
			request <= 1'b0;
			ready1  <= in_ready1;
			ready2  <= in_ready2;
		end else if (grant) begin
			busy    <= 1'b0; // freed as the slot takes the word.
			request <= 1'b0;
		end else if (busy) begin
			if (wake1) begin
				ready1 <= 1'b1;
			end
			if (wake2) begin
				ready2 <= 1'b1;
			end
			request <= ready1 && ready2;
		end
	end

	always_ff @(posedge clock) begin
		if (write_en) begin
			held_word <= write_word;
		end
	end

	no_write_while_busy: assert property (
		@(posedge clock) disable iff (reset) write_en |-> !busy
	) else $error("write_en to an occupied station");

	no_grant_without_request: assert property (
		@(posedge clock) disable iff (reset) grant |-> request
	) else $error("grant to a station that is not requesting");

endmodule

`default_nettype wire

// ==== source/rs_issue_select.sv ====
`default_nettype none

`include "rs_cfg.svh"

module rs_issue_select (
	input  logic              clock,
	input  logic              reset,
	input  logic [`RS_SZ-1:0] request,
	input  rs_pkg::rs_op_u    held_words [`RS_SZ],
	output logic [`RS_SZ-1:0] grant,
	output logic              issue_valid,
	output rs_pkg::rs_op_u    issue_word,
	input  logic              issue_ready
);

	localparam int sel_w = $clog2(`RS_SZ);

	logic [sel_w-1:0] sel;
	logic             any_req;
	logic             load_ok;

	// ##################################################
	// fixed priority pick
	// ##################################################

	always_comb begin
		sel = '0;
		for (int i = `RS_SZ - 1; i >= 0; i--) begin
			if (request[i]) begin
				sel = sel_w'(i); // lowest index ends up last.
			end
		end
	end

	assign any_req = |request;
	assign load_ok = !issue_valid || issue_ready; // slot empty or draining.

	always_comb begin
		grant = '0;
		if (load_ok && any_req) begin
			grant[sel] = 1'b1;
		end
	end

	// ##################################################
	// issue slot
	// ##################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else if (load_ok) begin
			issue_valid <= any_req;
		end
	end

	always_ff @(posedge clock) begin
		if (load_ok && any_req) begin
			issue_word <= held_words[sel];
		end
	end

	grant_onehot: assert property (
		@(posedge clock) disable iff (reset) $onehot0(grant)
	) else $error("more than one station granted");

	// back-pressure must not disturb the slot.
	slot_stable: assert property (
		@(posedge clock) disable iff (reset)
		(issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_word))
	) else $error("issue_word changed while stalled");

endmodule

`default_nettype wire

// ==== source/rs_pkg.sv ====
`default_nettype none

`include "rs_cfg.svh"

package rs_pkg;

	// ##################################################
	// unit classes and formats
	// ##################################################

	typedef enum logic [1:0] {
		class_alu   = 2'd0,
		class_load  = 2'd1,
		class_store = 2'd2,
		class_mul   = 2'd3
	} unit_class_e;

	localparam logic fmt_imm = 1'b1; // register form is zero.

	// ##################################################
	// dispatched word
	// ##################################################

	typedef struct packed {
		logic                                 fmt;
		unit_class_e                          unit_class;
		logic [`RS_TAG_W-1:0]                 dest;
		logic [`RS_TAG_W-1:0]                 src1;
		logic [`RS_TAG_W-1:0]                 src2;
		logic [`RS_IMM_W-`RS_TAG_W-1:0]       pad; // unused in register form.
	} reg_form_t;

	typedef struct packed {
		logic                 fmt;
		unit_class_e          unit_class;
		logic [`RS_TAG_W-1:0] dest;
		logic [`RS_TAG_W-1:0] src1;
		logic [`RS_IMM_W-1:0] imm;
	} imm_form_t;

	typedef union packed {
		logic [`RS_WORD_W-1:0] raw; // as seen on the bus.
		reg_form_t             reg_form;
		imm_form_t             imm_form;
	} rs_op_u;

endpackage

`default_nettype wire

// ==== source/rs_top.sv ====
`default_nettype none

`include "rs_cfg.svh"

module rs_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch_cyc,
	input  logic                  dispatch_stb,
	input  logic                  dispatch_we,
	input  logic [`RS_WORD_W-1:0] dispatch_dat,
	output logic                  dispatch_ack,
	input  logic                  cdb_valid,
	input  logic [`RS_TAG_W-1:0]  cdb_tag,
	output logic                  issue_valid,
	output rs_pkg::rs_op_u        issue_word,
	input  logic                  issue_ready
);

	logic [`RS_SZ-1:0] busy;
	logic [`RS_SZ-1:0] write_en;
	logic [`RS_SZ-1:0] request;
	logic [`RS_SZ-1:0] grant;
	rs_pkg::rs_op_u    write_word;
	rs_pkg::rs_op_u    held_words [`RS_SZ];

	rs_dispatch dispatch_i (
		.clock        (clock),
		.reset        (reset),
		.dispatch_cyc (dispatch_cyc),
		.dispatch_stb (dispatch_stb),
		.dispatch_we  (dispatch_we),
		.dispatch_dat (dispatch_dat),
		.dispatch_ack (dispatch_ack),
		.busy         (busy),
		.write_en     (write_en),
		.write_word   (write_word)
	);

	// one station per index, class fixed by position.
	for (genvar g = 0; g < `RS_SZ; g++) begin : g_entry
		rs_entry entry_i (
			.clock      (clock),
			.reset      (reset),
			.write_en   (write_en[g]),
			.write_word (write_word),
			.cdb_valid  (cdb_valid),
			.cdb_tag    (cdb_tag),
			.grant      (grant[g]),
			.busy       (busy[g]),
			.request    (request[g]),
			.held_word  (held_words[g])
		);
	end

	rs_issue_select select_i (
		.clock       (clock),
		.reset       (reset),
		.request     (request),
		.held_words  (held_words),
		.grant       (grant),
		.issue_valid (issue_valid),
		.issue_word  (issue_word),
		.issue_ready (issue_ready)
	);

endmodule

`default_nettype wire

// ==== verification/rs_tb.sv ====
`default_nettype none

`include "rs_cfg.svh"

module rs_tb;

	localparam int n_ops = 120;
	localparam int depth = 8; // reference table, above stations plus slot.
	localparam int timeout_cycles = 40 * n_ops + 200;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  dispatch_cyc;
	logic                  dispatch_stb;
	logic                  dispatch_we;
	logic [`RS_WORD_W-1:0] dispatch_dat;
	logic                  dispatch_ack;
	logic                  cdb_valid;
	logic [`RS_TAG_W-1:0]  cdb_tag;
	logic                  issue_valid;
	rs_pkg::rs_op_u        issue_word;
	logic                  issue_ready;

	logic                  p_valid [depth]; // acknowledged, not yet issued.
	rs_pkg::rs_op_u        p_word [depth];
	logic                  p_r1 [depth];
	logic                  p_r2 [depth];
	logic [`RS_TAG_W-1:0]  completed [$]; // issued, dest not yet broadcast.
	logic                  last_cdb_valid;
	logic [`RS_TAG_W-1:0]  last_cdb_tag;
	rs_pkg::rs_op_u        stall_word;
	logic [31:0]           rng = 32'd38;
	int                    issued_cnt;
	int                    err_issue = 0;
	int                    err_ack = 0;
	int                    err_stall = 0;
	int                    err_end = 0;
	logic                  req_open;
	logic                  issue_match;
	int                    dispatch_occ;
	int                    dispatch_cap;

	rs_top dut_i (.*);

	always #2 clock = ~clock;

	// ##################################################
	// helpers
	// ##################################################

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic int class_cap(input logic [1:0] cls);
		int n = 0;
		for (int i = 0; i < `RS_SZ; i++) begin
			if (`RS_CLASS_OF(i) == cls) begin
				n++;
			end
		end
		return n;
	endfunction

	// the op sitting in the issue slot has already left its station.
	function automatic int class_occupancy(input logic [1:0] cls);
		int n = 0;
		for (int i = 0; i < depth; i++) begin
			if (p_valid[i] && p_word[i].reg_form.unit_class == cls) begin
				n++;
			end
		end
		if (issue_valid && issue_word.reg_form.unit_class == cls) begin
			n--;
		end
		return n;
	endfunction

	function automatic logic outstanding();
		for (int i = 0; i < depth; i++) begin
			if (p_valid[i]) begin
				return 1'b1;
			end
		end
		return completed.size() > 0;
	endfunction

	// zero, or a dest tag that has not been broadcast yet.
	function automatic logic [`RS_TAG_W-1:0] pick_source();
		logic [`RS_TAG_W-1:0] live [$];
		for (int i = 0; i < depth; i++) begin
			if (p_valid[i]) begin
				live.push_back(p_word[i].reg_form.dest);
			end
		end
		foreach (completed[j]) begin
			live.push_back(completed[j]);
		end
		if (live.size() == 0 || next_rand() % 3 == 0) begin
			return '0;
		end
		return live[next_rand() % live.size()];
	endfunction

	// ops 0..3 open with an alu op and three multiplies, the first two wait on it.
	function automatic rs_pkg::rs_op_u make_op(input int idx, input logic [`RS_TAG_W-1:0] dest);
		rs_pkg::rs_op_u w;
		logic [1:0]     cls;
		logic           free;
		w.raw = '0;
		cls = (idx == 0) ? 2'd0 : (idx < 4) ? 2'd3 : 2'(next_rand());
		free = class_occupancy(cls) < class_cap(cls); // sources only when no stall.
		w.reg_form.unit_class = rs_pkg::unit_class_e'(cls);
		w.reg_form.dest = dest;
		if (idx == 0 || (idx >= 4 && next_rand() % 2 == 1)) begin
			w.imm_form.fmt = rs_pkg::fmt_imm;
			w.imm_form.imm = `RS_IMM_W'(next_rand() % 64); // looks like a tag.
			if (free && idx > 0) begin
				w.imm_form.src1 = pick_source();
			end
		end else if (idx < 3) begin
			w.reg_form.src1 = 1;
		end else if (free && idx >= 4) begin
			w.reg_form.src1 = pick_source();
			w.reg_form.src2 = pick_source();
		end
		return w;
	endfunction

	function automatic logic seen_tag(input logic [`RS_TAG_W-1:0] tag);
		return tag == '0 || (last_cdb_valid && last_cdb_tag == tag) || (cdb_valid && cdb_tag == tag);
	endfunction

	// ##################################################
	// reference bookkeeping
	// ##################################################

	always @(posedge clock) begin
		int slot;
		if (reset) begin
			foreach (p_valid[i]) begin
				p_valid[i] = 1'b0;
			end
			completed.delete();
			last_cdb_valid = 1'b0;
			issued_cnt = 0;
		end else begin
			for (int i = 0; i < depth; i++) begin
				if (p_valid[i] && cdb_valid && p_word[i].reg_form.src1 == cdb_tag) begin
					p_r1[i] = 1'b1;
				end
				if (p_valid[i] && cdb_valid && p_word[i].reg_form.src2 == cdb_tag
					&& p_word[i].reg_form.fmt != rs_pkg::fmt_imm) begin
					p_r2[i] = 1'b1;
				end
			end
			if (issue_valid && issue_ready) begin
				issued_cnt++;
				completed.push_back(issue_word.reg_form.dest); // unit finishes at once.
				for (int i = 0; i < depth; i++) begin
					if (p_valid[i] && p_word[i].raw == issue_word.raw) begin
						p_valid[i] = 1'b0;
						break;
					end
				end
			end
			if (dispatch_ack) begin
				slot = 0;
				for (int i = depth - 1; i >= 0; i--) begin
					if (!p_valid[i]) begin
						slot = i;
					end
				end
				p_valid[slot] = 1'b1;
				p_word[slot].raw = dispatch_dat;
				p_r1[slot] = seen_tag(p_word[slot].reg_form.src1); // write edge counts.
				p_r2[slot] = p_word[slot].reg_form.fmt == rs_pkg::fmt_imm
					|| seen_tag(p_word[slot].reg_form.src2);
			end
			last_cdb_valid = cdb_valid;
			last_cdb_tag = cdb_tag;
			if (issue_valid && !issue_ready) begin
				stall_word = issue_word;
			end
		end
	end

	always_comb begin
		rs_pkg::rs_op_u w;
		w.raw = dispatch_dat;
		req_open = dispatch_cyc && dispatch_stb && dispatch_we && !dispatch_ack;
		dispatch_occ = class_occupancy(w.reg_form.unit_class);
		dispatch_cap = class_cap(w.reg_form.unit_class);
		issue_match = 1'b0;
		for (int i = 0; i < depth; i++) begin
			if (p_valid[i] && p_r1[i] && p_r2[i] && p_word[i].raw == issue_word.raw) begin
				issue_match = 1'b1;
			end
		end
	end

	// ##################################################
	// checks
	// ##################################################

	issue_known: assert property (@(posedge clock) disable iff (reset)
		(issue_valid && issue_ready) |-> issue_match
	) else begin
		err_issue++;
		$display("ERR %0t: issue_word %h is not a pending op with all sources broadcast",
			$time, $sampled(issue_word.raw));
	end

	ack_when_free: assert property (@(posedge clock) disable iff (reset)
		(req_open && dispatch_occ < dispatch_cap) |=> dispatch_ack
	) else begin
		err_ack++;
		$display("ERR %0t: dispatch_ack expected 1 actual %b", $time, $sampled(dispatch_ack));
	end

	ack_when_full: assert property (@(posedge clock) disable iff (reset)
		(req_open && dispatch_occ >= dispatch_cap) |=> !dispatch_ack
	) else begin
		err_ack++;
		$display("ERR %0t: dispatch_ack expected 0 actual %b", $time, $sampled(dispatch_ack));
	end

	stall_hold: assert property (@(posedge clock) disable iff (reset)
		(issue_valid && !issue_ready) |=> (issue_valid && issue_word.raw == stall_word.raw)
	) else begin
		err_stall++;
		$display("ERR %0t: issue_word expected %h actual %h", $time,
			$sampled(stall_word.raw), $sampled(issue_word.raw));
	end

	// ##################################################
	// stimulus
	// ##################################################

	initial begin
		rs_pkg::rs_op_u       cur;
		logic [`RS_TAG_W-1:0] next_dest;
		logic                 in_flight;
		logic                 write_next;
		int                   sent;
		int                   k;
		reset = 1'b1;
		dispatch_cyc = 1'b0;
		dispatch_stb = 1'b0;
		dispatch_we = 1'b0;
		dispatch_dat = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		issue_ready = 1'b0; // opening op stays in the slot.
		cur.raw = '0;
		next_dest = 1;
		in_flight = 1'b0;
		sent = 0;
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		while (sent < n_ops || in_flight || dispatch_cyc || outstanding()) begin
			@(posedge clock);
			#1;
			if (dispatch_ack) begin
				in_flight = 1'b0; // cycle stays open through the ack.
			end else if (!in_flight && sent < n_ops) begin
				cur = make_op(sent, next_dest);
				next_dest = (next_dest == '1) ? 1 : next_dest + 1;
				dispatch_cyc = 1'b1;
				dispatch_stb = 1'b1;
				dispatch_we = 1'b1;
				dispatch_dat = cur.raw;
				in_flight = 1'b1;
				sent++;
			end else if (!in_flight) begin
				dispatch_cyc = 1'b0;
				dispatch_stb = 1'b0;
				dispatch_we = 1'b0;
			end
			write_next = in_flight && !dispatch_ack
				&& class_occupancy(cur.reg_form.unit_class) < class_cap(cur.reg_form.unit_class);
			cdb_valid = 1'b0;
			if (completed.size() > 0 && next_rand() % 4 != 0) begin
				k = next_rand() % completed.size();
				foreach (completed[j]) begin
					if (write_next && (completed[j] == cur.reg_form.src1
						|| (cur.reg_form.fmt != rs_pkg::fmt_imm && completed[j] == cur.reg_form.src2))) begin
						k = j; // broadcast lands on the write edge.
					end
				end
				cdb_valid = 1'b1;
				cdb_tag = completed[k];
				completed.delete(k);
			end
			issue_ready = (sent >= 4) && (next_rand() % 3 != 0);
		end
		if (issued_cnt != n_ops) begin
			err_end++;
			$display("issued %0d operations but dispatched %0d", issued_cnt, n_ops);
		end
		$display("errors: issue %0d, ack %0d, stall %0d, end %0d",
			err_issue, err_ack, err_stall, err_end);
		if (err_issue + err_ack + err_stall + err_end == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("timeout after %0d cycles with operations still outstanding", timeout_cycles);
		$display("errors: issue %0d, ack %0d, stall %0d, end %0d",
			err_issue, err_ack, err_stall, err_end);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
